// File: Bender.yml
package:
  name: mbs_dpath

sources:
  - hdl/mbs_pkg.sv
  - hdl/art_lookup.sv
  - hdl/art_perm_check.sv
  - hdl/lmb_resp.sv
  - hdl/mbs_dpath.sv
  - target: test
    files:
      - verif/mbs_dpath_assert.sv
      - verif/tb_mbs_dpath.sv

// File: hdl/art_lookup.sv
//==========================================================================
// Address region table lookup, two register stages.
// Entry 0 is a fixed single-granule window with full read/write access.
// Among programmable regions the lowest index wins on overlap.
// Region bounds are inclusive and must be stable while accesses run.
//==========================================================================

`timescale 1ns/1ps

module art_lookup #(
  parameter int NUM_REGIONS = 4
) (
  input  logic                           clk_cpu,
  input  logic                           rst_cpu,

  // CPU data access
  input  logic [mbs_pkg::ADR_W-1:0]      i_cpu_dadr,
  input  logic                           i_cpu_dstrobe,
  input  logic                           i_cpu_dwr,
  input  logic [mbs_pkg::BEN_W-1:0]      i_cpu_dben,
  input  logic [mbs_pkg::DATA_W-1:0]     i_cpu_dwdata,

  // Region table
  input  logic [mbs_pkg::RGN_ADR_W-1:0]  i_ctl_entry0_base,
  input  logic                           i_ctl_entry0_u_flag,
  input  logic [mbs_pkg::RGN_ADR_W-1:0]  i_ctl_rgn_base  [NUM_REGIONS],
  input  logic [mbs_pkg::RGN_ADR_W-1:0]  i_ctl_rgn_end   [NUM_REGIONS],
  input  mbs_pkg::rgn_flags_t            i_ctl_rgn_flags [NUM_REGIONS],
  input  logic [NUM_REGIONS-1:0]         i_ctl_rgn_valid,

  // Looked-up access toward the permission check
  output logic                           o_valid,
  output logic                           o_hit,
  output mbs_pkg::rgn_flags_t            o_flags,
  output logic [mbs_pkg::ADR_W-1:0]      o_adr,
  output logic                           o_wr,
  output logic [mbs_pkg::BEN_W-1:0]      o_ben,
  output logic [mbs_pkg::DATA_W-1:0]     o_wdata
);

  import mbs_pkg::*;

  logic                  s1_valid;
  logic [ADR_W-1:0]      s1_adr;
  logic                  s1_wr;
  logic [BEN_W-1:0]      s1_ben;
  logic [DATA_W-1:0]     s1_wdata;
  logic [RGN_ADR_W-1:0]  s1_granule;
  logic                  hit_d;
  rgn_flags_t            flags_d;

  //==========================================================================
  // Stage 1: capture the strobed access
  //==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (rst_cpu) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_cpu_dstrobe;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_cpu_dstrobe) begin
      s1_adr   <= i_cpu_dadr;
      s1_wr    <= i_cpu_dwr;
      s1_ben   <= i_cpu_dben;
      s1_wdata <= i_cpu_dwdata;
    end
  end

  assign s1_granule = s1_adr[ADR_W-1 -: RGN_ADR_W];

  //==========================================================================
  // Stage 2: region match
  //==========================================================================
  always_comb begin
    hit_d   = 1'b0;
    flags_d = '0;
    if (s1_granule == i_ctl_entry0_base) begin
      hit_d                  = 1'b1;
      flags_d[RGN_FLAG_RD]   = 1'b1;
      flags_d[RGN_FLAG_WR]   = 1'b1;
      flags_d[RGN_FLAG_USER] = i_ctl_entry0_u_flag;
    end else begin
      // Walk downwards so the lowest matching index is assigned last
      for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
        if (i_ctl_rgn_valid[i] &&
            (s1_granule >= i_ctl_rgn_base[i]) &&
            (s1_granule <= i_ctl_rgn_end[i])) begin
          hit_d   = 1'b1;
          flags_d = i_ctl_rgn_flags[i];
        end
      end
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (rst_cpu) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (s1_valid) begin
      o_hit   <= hit_d;
      o_flags <= flags_d;
      o_adr   <= s1_adr;
      o_wr    <= s1_wr;
      o_ben   <= s1_ben;
      o_wdata <= s1_wdata;
    end
  end

endmodule

// File: hdl/art_perm_check.sv
//==========================================================================
// Permission check and SRAM request issue, one register stage.
// Miss and permission faults are sticky until the controller acks;
// a fault in the same cycle as the ack keeps the flag set.
// The SRAM controller is assumed never to stall a request.
//==========================================================================

`timescale 1ns/1ps

module art_perm_check (
  input  logic                            clk_cpu,
  input  logic                            rst_cpu,

  // Looked-up access
  input  logic                            i_valid,
  input  logic                            i_hit,
  input  mbs_pkg::rgn_flags_t             i_flags,
  input  logic [mbs_pkg::ADR_W-1:0]       i_adr,
  input  logic                            i_wr,
  input  logic [mbs_pkg::BEN_W-1:0]       i_ben,
  input  logic [mbs_pkg::DATA_W-1:0]      i_wdata,

  // Controller
  input  logic                            i_privileged,
  input  logic                            i_fault_ack,
  output logic                            o_miss_fault,
  output logic                            o_perm_fault,

  // SRAM controller request
  output logic [mbs_pkg::SRAM_ADR_W-1:0]  o_sctl_req_adr,
  output logic                            o_sctl_req_we,
  output logic [mbs_pkg::DATA_W-1:0]      o_sctl_req_wdata,
  output logic [mbs_pkg::BEN_W-1:0]       o_sctl_req_be,
  output logic                            o_sctl_req_valid,

  // One-cycle fault indication toward the CPU response
  output logic                            o_fault_pulse
);

  import mbs_pkg::*;

  logic refused;
  logic miss_evt;
  logic perm_evt;

  // Any one missing permission refuses the access
  assign refused = (i_wr  & ~i_flags[RGN_FLAG_WR]) |
                   (~i_wr & ~i_flags[RGN_FLAG_RD]) |
                   (~i_privileged & ~i_flags[RGN_FLAG_USER]);

  assign miss_evt = i_valid & ~i_hit;
  assign perm_evt = i_valid & i_hit & refused;

  //==========================================================================
  // Stage 3: decision
  //==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (rst_cpu) begin
      o_sctl_req_valid <= 1'b0;
      o_fault_pulse    <= 1'b0;
      o_miss_fault     <= 1'b0;
      o_perm_fault     <= 1'b0;
    end else begin
      o_sctl_req_valid <= i_valid & i_hit & ~refused;
      o_fault_pulse    <= miss_evt | perm_evt;

      // New fault takes priority over the ack
      if (miss_evt) begin
        o_miss_fault <= 1'b1;
      end else if (i_fault_ack) begin
        o_miss_fault <= 1'b0;
      end

      if (perm_evt) begin
        o_perm_fault <= 1'b1;
      end else if (i_fault_ack) begin
        o_perm_fault <= 1'b0;
      end
    end
  end

  // Request fields, qualified by o_sctl_req_valid
  always_ff @(posedge clk_cpu) begin
    if (i_valid) begin
      o_sctl_req_adr   <= i_adr[SRAM_ADR_W+1:2];
      o_sctl_req_we    <= i_wr;
      o_sctl_req_wdata <= i_wdata;
      o_sctl_req_be    <= i_ben;
    end
  end

endmodule

// File: hdl/lmb_resp.sv
//==========================================================================
// CPU data port response. Writes and faults complete in the issue cycle,
// reads one cycle after the SRAM answers. Only one access is in flight.
//==========================================================================

`timescale 1ns/1ps

module lmb_resp (
  input  logic                         clk_cpu,
  input  logic                         rst_cpu,

  // From the permission check
  input  logic                         i_req_valid,
  input  logic                         i_req_we,
  input  logic                         i_fault_pulse,

  // SRAM controller response
  input  logic [mbs_pkg::DATA_W-1:0]   i_sctl_resp_rdata,
  input  logic                         i_sctl_resp_valid,

  // CPU data port
  output logic [mbs_pkg::DATA_W-1:0]   o_cpu_drdata,
  output logic                         o_cpu_dready
);

  import mbs_pkg::*;

  logic              rd_pend;
  logic              rd_ret_q;
  logic [DATA_W-1:0] rdata_q;

  // Read outstanding at the SRAM
  always_ff @(posedge clk_cpu) begin
    if (rst_cpu) begin
      rd_pend  <= 1'b0;
      rd_ret_q <= 1'b0;
    end else begin
      if (i_req_valid && !i_req_we) begin
        rd_pend <= 1'b1;
      end else if (i_sctl_resp_valid) begin
        rd_pend <= 1'b0;
      end
      rd_ret_q <= i_sctl_resp_valid & rd_pend;
    end
  end

  // Zero unless a read is returning
  always_ff @(posedge clk_cpu) begin
    rdata_q <= (i_sctl_resp_valid && rd_pend) ? i_sctl_resp_rdata : '0;
  end

  assign o_cpu_drdata = rdata_q;
  assign o_cpu_dready = (i_req_valid & i_req_we) | i_fault_pulse | rd_ret_q;

endmodule

// File: hdl/mbs_dpath.sv
//==========================================================================
// MBS CPU data path: region lookup, permission check, CPU response.
// Single clock domain. The CPU waits for o_cpu_dready between accesses.
// Region table inputs are static levels from the controller.
//==========================================================================

`timescale 1ns/1ps

module mbs_dpath #(
  parameter int NUM_REGIONS = 4
) (
  input  logic                            clk_cpu,
  input  logic                            rst_cpu,

  // CPU data port
  input  logic [mbs_pkg::ADR_W-1:0]       i_cpu_dadr,
  input  logic                            i_cpu_dstrobe,
  input  logic                            i_cpu_dwr,
  input  logic [mbs_pkg::BEN_W-1:0]       i_cpu_dben,
  input  logic [mbs_pkg::DATA_W-1:0]      i_cpu_dwdata,
  output logic [mbs_pkg::DATA_W-1:0]      o_cpu_drdata,
  output logic                            o_cpu_dready,

  // Controller
  input  logic [mbs_pkg::RGN_ADR_W-1:0]   i_ctl_entry0_base,
  input  logic                            i_ctl_entry0_u_flag,
  input  logic [mbs_pkg::RGN_ADR_W-1:0]   i_ctl_rgn_base  [NUM_REGIONS],
  input  logic [mbs_pkg::RGN_ADR_W-1:0]   i_ctl_rgn_end   [NUM_REGIONS],
  input  mbs_pkg::rgn_flags_t             i_ctl_rgn_flags [NUM_REGIONS],
  input  logic [NUM_REGIONS-1:0]          i_ctl_rgn_valid,
  input  logic                            i_ctl_privileged,
  input  logic                            i_ctl_fault_ack,
  output logic                            o_ctl_miss_fault,
  output logic                            o_ctl_perm_fault,

  // SRAM controller
  output logic [mbs_pkg::SRAM_ADR_W-1:0]  o_sctl_req_adr,
  output logic                            o_sctl_req_we,
  output logic [mbs_pkg::DATA_W-1:0]      o_sctl_req_wdata,
  output logic [mbs_pkg::BEN_W-1:0]       o_sctl_req_be,
  output logic                            o_sctl_req_valid,
  input  logic [mbs_pkg::DATA_W-1:0]      i_sctl_resp_rdata,
  input  logic                            i_sctl_resp_valid
);

  import mbs_pkg::*;

  // Lookup to permission check
  logic              lk_valid;
  logic              lk_hit;
  rgn_flags_t        lk_flags;
  logic [ADR_W-1:0]  lk_adr;
  logic              lk_wr;
  logic [BEN_W-1:0]  lk_ben;
  logic [DATA_W-1:0] lk_wdata;

  // Permission check to CPU response
  logic              pc_fault_pulse;

  //==========================================================================
  // Stages
  //==========================================================================
  art_lookup #(
    .NUM_REGIONS         (NUM_REGIONS)
  ) u_art_lookup (
    .clk_cpu             (clk_cpu),
    .rst_cpu             (rst_cpu),
    .i_cpu_dadr          (i_cpu_dadr),
    .i_cpu_dstrobe       (i_cpu_dstrobe),
    .i_cpu_dwr           (i_cpu_dwr),
    .i_cpu_dben          (i_cpu_dben),
    .i_cpu_dwdata        (i_cpu_dwdata),
    .i_ctl_entry0_base   (i_ctl_entry0_base),
    .i_ctl_entry0_u_flag (i_ctl_entry0_u_flag),
    .i_ctl_rgn_base      (i_ctl_rgn_base),
    .i_ctl_rgn_end       (i_ctl_rgn_end),
    .i_ctl_rgn_flags     (i_ctl_rgn_flags),
    .i_ctl_rgn_valid     (i_ctl_rgn_valid),
    .o_valid             (lk_valid),
    .o_hit               (lk_hit),
    .o_flags             (lk_flags),
    .o_adr               (lk_adr),
    .o_wr                (lk_wr),
    .o_ben               (lk_ben),
    .o_wdata             (lk_wdata)
  );

  art_perm_check u_art_perm_check (
    .clk_cpu             (clk_cpu),
    .rst_cpu             (rst_cpu),
    .i_valid             (lk_valid),
    .i_hit               (lk_hit),
    .i_flags             (lk_flags),
    .i_adr               (lk_adr),
    .i_wr                (lk_wr),
    .i_ben               (lk_ben),
    .i_wdata             (lk_wdata),
    .i_privileged        (i_ctl_privileged),
    .i_fault_ack         (i_ctl_fault_ack),
    .o_miss_fault        (o_ctl_miss_fault),
    .o_perm_fault        (o_ctl_perm_fault),
    .o_sctl_req_adr      (o_sctl_req_adr),
    .o_sctl_req_we       (o_sctl_req_we),
    .o_sctl_req_wdata    (o_sctl_req_wdata),
    .o_sctl_req_be       (o_sctl_req_be),
    .o_sctl_req_valid    (o_sctl_req_valid),
    .o_fault_pulse       (pc_fault_pulse)
  );

  lmb_resp u_lmb_resp (
    .clk_cpu             (clk_cpu),
    .rst_cpu             (rst_cpu),
    .i_req_valid         (o_sctl_req_valid),
    .i_req_we            (o_sctl_req_we),
    .i_fault_pulse       (pc_fault_pulse),
    .i_sctl_resp_rdata   (i_sctl_resp_rdata),
    .i_sctl_resp_valid   (i_sctl_resp_valid),
    .o_cpu_drdata        (o_cpu_drdata),
    .o_cpu_dready        (o_cpu_dready)
  );

endmodule

// File: hdl/mbs_pkg.sv
//==========================================================================
// Shared widths and region flag encoding for the MBS CPU data path.
// Addresses are byte addresses; SRAM is addressed by 32-bit word.
// A region granule is the top RGN_ADR_W address bits (1 MB each).
//==========================================================================

package mbs_pkg;

  //==========================================================================
  // CPU data port
  //==========================================================================
  localparam int ADR_W  = 32;
  localparam int DATA_W = 32;
  localparam int BEN_W  = 4;

  //==========================================================================
  // Region table
  //==========================================================================
  // Granule compare uses address bits 31..20
  localparam int RGN_ADR_W = 12;

  // Word address toward the SRAM controller, bits 19..2
  localparam int SRAM_ADR_W = 18;

  // Flag bits
  localparam int RGN_FLAG_W    = 3;
  localparam int RGN_FLAG_RD   = 0;
  localparam int RGN_FLAG_WR   = 1;
  localparam int RGN_FLAG_USER = 2;

  // Read, write and user permission of one region
  typedef logic [RGN_FLAG_W-1:0] rgn_flags_t;

endpackage

// File: mbs_dpath.f
hdl/mbs_pkg.sv
hdl/art_lookup.sv
hdl/art_perm_check.sv
hdl/lmb_resp.sv
hdl/mbs_dpath.sv
verif/mbs_dpath_assert.sv
verif/tb_mbs_dpath.sv

// File: verif/mbs_dpath_assert.sv
//==========================================================================
// Protocol assertions bound into every mbs_dpath instance.
// The one-cycle pulse checks hold only while the CPU keeps a single
// access in flight.
//==========================================================================

`timescale 1ns/1ps

module mbs_dpath_assert (
  input logic clk_cpu,
  input logic rst_cpu,
  input logic i_req_valid,
  input logic i_cpu_dready,
  input logic i_miss_fault,
  input logic i_perm_fault
);

  int n_fail = 0;

  property one_cycle_pulse(sig);
    @(posedge clk_cpu) disable iff (rst_cpu) sig |=> !sig;
  endproperty

  a_req_pulse: assert property (one_cycle_pulse(i_req_valid))
    else begin
      n_fail++;
      $error("SRAM request valid held for more than one cycle");
    end

  a_ready_pulse: assert property (one_cycle_pulse(i_cpu_dready))
    else begin
      n_fail++;
      $error("CPU data ready held for more than one cycle");
    end

  // A request and a fault never come from the same access
  a_no_fault_with_req: assert property (
    @(posedge clk_cpu) disable iff (rst_cpu)
      i_req_valid |-> !$rose(i_miss_fault) && !$rose(i_perm_fault))
    else begin
      n_fail++;
      $error("Fault flag rose together with an SRAM request");
    end

  a_reset_quiet: assert property (
    @(posedge clk_cpu)
      rst_cpu |=> !i_req_valid && !i_cpu_dready && !i_miss_fault && !i_perm_fault)
    else begin
      n_fail++;
      $error("Outputs not quiet during reset");
    end

endmodule

bind mbs_dpath mbs_dpath_assert u_mbs_dpath_assert (
  .clk_cpu      (clk_cpu),
  .rst_cpu      (rst_cpu),
  .i_req_valid  (o_sctl_req_valid),
  .i_cpu_dready (o_cpu_dready),
  .i_miss_fault (o_ctl_miss_fault),
  .i_perm_fault (o_ctl_perm_fault)
);

// File: verif/tb_mbs_dpath.sv
//==========================================================================
// Testbench for the CPU data path with a behavioral SRAM controller.
// Read delay of the SRAM model is random, 1 to 6 cycles; writes get no
// answer. Unwritten SRAM words return an address-derived fill pattern.
//==========================================================================

`timescale 1ns/1ps

module tb_mbs_dpath;

  import mbs_pkg::*;

  localparam int NUM_REGIONS = 4;
  localparam int CLK_NS      = 8;
  localparam int RST_CYCLES  = 10;
  localparam int N_DIRECTED  = 10;
  localparam int N_RANDOM    = 200;
  localparam int WDOG_CYCLES = RST_CYCLES + (N_DIRECTED + N_RANDOM) * 20;
  localparam logic [1:0] KIND_REQ  = 2'd0;
  localparam logic [1:0] KIND_MISS = 2'd1;
  localparam logic [1:0] KIND_PERM = 2'd2;
  localparam logic [1:0] KIND_ANY  = 2'd3;

  logic clk_cpu;
  logic rst_cpu;
  logic [ADR_W-1:0] i_cpu_dadr;
  logic i_cpu_dstrobe;
  logic i_cpu_dwr;
  logic [BEN_W-1:0] i_cpu_dben;
  logic [DATA_W-1:0] i_cpu_dwdata;
  logic [DATA_W-1:0] o_cpu_drdata;
  logic o_cpu_dready;
  logic [RGN_ADR_W-1:0] i_ctl_entry0_base;
  logic i_ctl_entry0_u_flag;
  logic [RGN_ADR_W-1:0] i_ctl_rgn_base [NUM_REGIONS];
  logic [RGN_ADR_W-1:0] i_ctl_rgn_end [NUM_REGIONS];
  rgn_flags_t i_ctl_rgn_flags [NUM_REGIONS];
  logic [NUM_REGIONS-1:0] i_ctl_rgn_valid;
  logic i_ctl_privileged;
  logic i_ctl_fault_ack;
  logic o_ctl_miss_fault;
  logic o_ctl_perm_fault;
  logic [SRAM_ADR_W-1:0] o_sctl_req_adr;
  logic o_sctl_req_we;
  logic [DATA_W-1:0] o_sctl_req_wdata;
  logic [BEN_W-1:0] o_sctl_req_be;
  logic o_sctl_req_valid;
  logic [DATA_W-1:0] i_sctl_resp_rdata = '0;
  logic i_sctl_resp_valid = 1'b0;

  integer seed = 34640;
  logic [DATA_W-1:0] sram_mem [int];
  logic [DATA_W-1:0] ref_mem [int];
  logic [SRAM_ADR_W-1:0] rd_adr;
  logic [DATA_W-1:0] old_word;
  logic [31:0] rnd;
  int rd_cnt;
  int n_issued = 0;
  int n_ready = 0;

  // Expected outcome of the access in flight
  logic [1:0] exp_kind = KIND_MISS;
  logic [SRAM_ADR_W-1:0] exp_adr;
  logic exp_wr;
  logic [BEN_W-1:0] exp_ben;
  logic [DATA_W-1:0] exp_wdata;
  logic [DATA_W-1:0] exp_rdata;
  time t_strobe = 0;

  mbs_dpath #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_mbs_dpath (.*);

  initial begin
    clk_cpu = 1'b0;
    forever #(CLK_NS / 2) clk_cpu = ~clk_cpu;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_cpu);
    $display("Watchdog expired: the data path stopped answering accesses");
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  function automatic logic [DATA_W-1:0] fill_word(input logic [SRAM_ADR_W-1:0] a);
    return {a, a[17:4]} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
      input logic [DATA_W-1:0] wdata, input logic [BEN_W-1:0] ben);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < BEN_W; b++) begin
      if (ben[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // Entry 0 first, then the lowest matching valid region
  function automatic logic [1:0] ref_access(input logic [ADR_W-1:0] adr, input logic wr,
      input logic priv);
    logic [RGN_ADR_W-1:0] gran;
    logic hit;
    rgn_flags_t fl;
    gran = adr[31:20];
    hit  = 1'b0;
    fl   = '0;
    if (gran == i_ctl_entry0_base) begin
      hit = 1'b1;
      fl[RGN_FLAG_RD]   = 1'b1;
      fl[RGN_FLAG_WR]   = 1'b1;
      fl[RGN_FLAG_USER] = i_ctl_entry0_u_flag;
    end else begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (!hit && i_ctl_rgn_valid[i] && gran >= i_ctl_rgn_base[i] &&
            gran <= i_ctl_rgn_end[i]) begin
          hit = 1'b1;
          fl  = i_ctl_rgn_flags[i];
        end
      end
    end
    if (!hit) return KIND_MISS;
    if ((wr && !fl[RGN_FLAG_WR]) || (!wr && !fl[RGN_FLAG_RD]) ||
        (!priv && !fl[RGN_FLAG_USER])) return KIND_PERM;
    return KIND_REQ;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("TB FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  //==========================================================================
  // SRAM controller model
  //==========================================================================
  always @(posedge clk_cpu) begin
    i_sctl_resp_valid <= 1'b0;
    if (rst_cpu) begin
      rd_cnt <= 0;
    end else begin
      if (rd_cnt == 1) begin
        i_sctl_resp_valid <= 1'b1;
        i_sctl_resp_rdata <= sram_mem.exists(rd_adr) ? sram_mem[rd_adr] : fill_word(rd_adr);
      end
      if (rd_cnt != 0) rd_cnt <= rd_cnt - 1;
      if (o_sctl_req_valid && o_sctl_req_we) begin
        old_word = sram_mem.exists(o_sctl_req_adr) ? sram_mem[o_sctl_req_adr] :
                   fill_word(o_sctl_req_adr);
        sram_mem[o_sctl_req_adr] = merge_bytes(old_word, o_sctl_req_wdata, o_sctl_req_be);
      end else if (o_sctl_req_valid) begin
        rd_adr <= o_sctl_req_adr;
        rd_cnt <= 1 + ($unsigned($random(seed)) % 6);
      end
    end
  end

  //==========================================================================
  // Compare DUT responses with the expected outcome
  //==========================================================================
  always @(posedge clk_cpu) begin
    if (!rst_cpu) begin
      check_val("failed assertions", u_mbs_dpath.u_mbs_dpath_assert.n_fail, 0);
      if (o_sctl_req_valid) begin
        check_val("outcome with SRAM request", KIND_REQ, exp_kind);
        // Decision registers change at the third edge after the strobe edge
        check_val("cycles from strobe to request", ($time - t_strobe) / CLK_NS - 1, 3);
        check_val("request address", o_sctl_req_adr, exp_adr);
        check_val("request write enable", o_sctl_req_we, exp_wr);
        check_val("request write data", o_sctl_req_wdata, exp_wdata);
        check_val("request byte enables", o_sctl_req_be, exp_ben);
      end
      if (o_cpu_dready) begin
        n_ready++;
        check_val("CPU read data", o_cpu_drdata, exp_rdata);
        check_val("request with ready", o_sctl_req_valid, exp_kind == KIND_REQ && exp_wr);
        check_val("miss fault flag", o_ctl_miss_fault, exp_kind == KIND_MISS);
        check_val("permission fault flag", o_ctl_perm_fault, exp_kind == KIND_PERM);
        if (exp_kind != KIND_REQ) begin
          check_val("cycles from strobe to fault", ($time - t_strobe) / CLK_NS - 1, 3);
        end
      end
    end
  end

  // Sets the expected outcome, then strobes one access
  task automatic issue_access(input logic [ADR_W-1:0] adr, input logic wr,
      input logic [BEN_W-1:0] ben, input logic [DATA_W-1:0] wdata, input logic [1:0] want);
    logic [SRAM_ADR_W-1:0] wa;
    logic [DATA_W-1:0] old;
    wa = adr[19:2];
    @(posedge clk_cpu);
    exp_kind  = ref_access(adr, wr, i_ctl_privileged);
    exp_adr   = wa;
    exp_wr    = wr;
    exp_ben   = ben;
    exp_wdata = wdata;
    old       = ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
    exp_rdata = (exp_kind == KIND_REQ && !wr) ? old : '0;
    if (exp_kind == KIND_REQ && wr) ref_mem[wa] = merge_bytes(old, wdata, ben);
    if (want != KIND_ANY) check_val("directed outcome", exp_kind, want);
    n_issued++;
    t_strobe = $time;
    i_cpu_dadr    <= adr;
    i_cpu_dwr     <= wr;
    i_cpu_dben    <= ben;
    i_cpu_dwdata  <= wdata;
    i_cpu_dstrobe <= 1'b1;
    @(posedge clk_cpu);
    i_cpu_dstrobe <= 1'b0;
  endtask

  task automatic wait_ready();
    do @(posedge clk_cpu); while (!o_cpu_dready);
  endtask

  task automatic run_access(input logic [ADR_W-1:0] adr, input logic wr,
      input logic [BEN_W-1:0] ben, input logic [DATA_W-1:0] wdata, input logic [1:0] want);
    issue_access(adr, wr, ben, wdata, want);
    wait_ready();
  endtask

  task automatic ack_faults();
    @(posedge clk_cpu);
    i_ctl_fault_ack <= 1'b1;
    @(posedge clk_cpu);
    i_ctl_fault_ack <= 1'b0;
    @(posedge clk_cpu);
    check_val("miss fault after ack", o_ctl_miss_fault, 0);
    check_val("permission fault after ack", o_ctl_perm_fault, 0);
  endtask

  task automatic set_region(input int i, input logic [RGN_ADR_W-1:0] base,
      input logic [RGN_ADR_W-1:0] last, input rgn_flags_t flags, input logic valid);
    i_ctl_rgn_base[i]  <= base;
    i_ctl_rgn_end[i]   <= last;
    i_ctl_rgn_flags[i] <= flags;
    i_ctl_rgn_valid[i] <= valid;
  endtask

  task automatic randomize_regions();
    logic [RGN_ADR_W-1:0] b;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      b = $random(seed) & 12'hf;
      set_region(i, b, b + ($random(seed) & 3), $random(seed), $random(seed));
    end
    i_ctl_entry0_base   <= $random(seed) & 12'hf;
    i_ctl_entry0_u_flag <= $random(seed);
  endtask

  //==========================================================================
  // Stimulus
  //==========================================================================
  initial begin
    rst_cpu             <= 1'b1;
    i_cpu_dadr          <= '0;
    i_cpu_dstrobe       <= 1'b0;
    i_cpu_dwr           <= 1'b0;
    i_cpu_dben          <= '0;
    i_cpu_dwdata        <= '0;
    i_ctl_entry0_base   <= 12'h005;
    i_ctl_entry0_u_flag <= 1'b1;
    i_ctl_privileged    <= 1'b1;
    i_ctl_fault_ack     <= 1'b0;
    // Overlapping regions, region 3 invalid
    set_region(0, 12'h001, 12'h003, 3'b111, 1'b1);
    set_region(1, 12'h002, 12'h006, 3'b101, 1'b1);
    set_region(2, 12'h008, 12'h009, 3'b011, 1'b1);
    set_region(3, 12'h000, 12'h00f, 3'b111, 1'b0);
    repeat (RST_CYCLES) @(posedge clk_cpu);
    rst_cpu <= 1'b0;
    @(posedge clk_cpu);
    check_val("request valid after reset", o_sctl_req_valid, 0);
    check_val("ready after reset", o_cpu_dready, 0);
    check_val("miss fault after reset", o_ctl_miss_fault, 0);
    check_val("permission fault after reset", o_ctl_perm_fault, 0);

    // Entry 0 window beats region 1, then region 0 beats region 1
    run_access(32'h0050_1234, 1'b1, 4'b1111, 32'hcafe_f00d, KIND_REQ);
    run_access(32'h0050_1234, 1'b0, 4'b1111, 32'h0, KIND_REQ);
    run_access(32'h0020_0040, 1'b1, 4'b0101, 32'h1234_5678, KIND_REQ);
    run_access(32'h0020_0040, 1'b0, 4'b1111, 32'h0, KIND_REQ);

    // Miss outside every valid region, flag held until ack
    run_access(32'h00c0_0010, 1'b0, 4'b1111, 32'h0, KIND_MISS);
    repeat (5) @(posedge clk_cpu);
    check_val("miss fault held", o_ctl_miss_fault, 1);
    ack_faults();

    // Write to region 1 lacks write permission
    run_access(32'h0040_0040, 1'b1, 4'b1111, 32'h5555_aaaa, KIND_PERM);
    ack_faults();

    // User mode on a region without the user flag
    i_ctl_privileged <= 1'b0;
    run_access(32'h0080_0000, 1'b0, 4'b1111, 32'h0, KIND_PERM);
    issue_access(32'h0080_0004, 1'b0, 4'b1111, 32'h0, KIND_PERM);
    // Ack lands in the same cycle as the new fault
    @(posedge clk_cpu);
    i_ctl_fault_ack <= 1'b1;
    @(posedge clk_cpu);
    i_ctl_fault_ack <= 1'b0;
    wait_ready();
    check_val("permission fault kept over ack", o_ctl_perm_fault, 1);
    ack_faults();
    i_ctl_privileged <= 1'b1;

    for (int n = 0; n < N_RANDOM; n++) begin
      if (n % 25 == 0) randomize_regions();
      i_ctl_privileged <= $random(seed);
      rnd = $random(seed);
      run_access({8'h00, rnd[3:0], rnd[23:4]}, rnd[31], $random(seed), $random(seed),
                 KIND_ANY);
      if (exp_kind != KIND_REQ) begin
        ack_faults();
      end
    end

    repeat (4) @(posedge clk_cpu);
    check_val("number of ready pulses", n_ready, n_issued);
    check_val("failed assertions", u_mbs_dpath.u_mbs_dpath_assert.n_fail, 0);
    $display("TB PASSED");
    $finish;
  end

endmodule
